// ==== compile.f ====
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/shared_memory.sv
src/cpu_core.sv
tests/cpu_props.sv
tests/cpu_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module cpu_tb -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/Vcpu_tb

clean:
	rm -rf obj_dir

// ==== tests/cpu_tb.sv ====
// Testbench for cpu_core: loads generated programs, runs them and compares registers with an ISS
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;
   import cpu_pkg::*;

   localparam int MEM_WORDS = 2**`CPU_MEM_AW;

   logic                   clk;
   logic                   rst_n;
   logic                   run;
   logic                   load_we;
   logic [`CPU_MEM_AW-1:0] load_addr;
   logic [15:0]            load_data;
   logic [2:0]             dbg_addr;
   logic [15:0]            dbg_data;
   logic                   halted;
   logic                   err;

   logic [15:0]      image [MEM_WORDS];
   int               wp;
   logic [31:0]      lfsr = 32'hde52_615d;
   string            test_name;
   logic [7:0][15:0] exp_regs;
   logic             exp_err;
   logic [15:0]      dut_regs [8];
   logic             cmp_done;
   event             cmp_ev;

   cpu_core uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .dbg_addr  (dbg_addr),
      .dbg_data  (dbg_data),
      .halted    (halted),
      .err       (err)
   );

   always #50 clk = ~clk;

   task automatic stop_failed();
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(string what, logic [15:0] expected, logic [15:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
         stop_failed();
      end
   endtask

   // Galois LFSR, one step per bit
   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] v;
      logic        b;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         b = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
         end
         v = {v[14:0], b};
      end
      return v;
   endfunction

   // Any register but the data base r7
   function automatic logic [2:0] pick_reg();
      logic [2:0] v;
      v = 3'(rand_bits(3));
      return (v == 3'd7) ? 3'd0 : v;
   endfunction

   function automatic logic [15:0] enc_r(funct_e f, logic [2:0] rd, logic [2:0] rs,
                                         logic [2:0] rt);
      return {RTYPE, rd, rs, rt, f};
   endfunction

   function automatic logic [15:0] enc_i(opcode_e op, logic [2:0] rd, logic [2:0] rs,
                                         logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   task automatic emit(logic [15:0] w);
      image[wp] = w;
      wp++;
   endtask

   // Unused words hold a halt tagged with their address
   task automatic clear_image();
      int k;
      for (k = 0; k < MEM_WORDS; k++) begin
         image[k] = 16'hf000 | 16'(k);
      end
      wp = `CPU_RESET_PC;
   endtask

   task automatic gen_alu(int count, logic illegal);
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] f;
      logic [2:0] last_rd;
      int         k;
      clear_image();
      last_rd = 3'd0;
      for (k = 0; k < 8; k++) begin
         emit(enc_i(ADDI, 3'(k), 3'(k), 6'(rand_bits(6))));
      end
      for (k = 0; k < count; k++) begin
         rd = 3'(rand_bits(3));
         // Half the time the source is the previous result
         rs = (rand_bits(1) != 16'd0) ? last_rd : 3'(rand_bits(3));
         f  = 3'(rand_bits(3));
         if (f > 3'd5) begin
            f = f - 3'd6;
         end
         if (illegal && k == count / 2) begin
            emit({4'h7, 12'(rand_bits(12))});
         end else if (illegal && k == count / 2 + 1) begin
            emit({RTYPE, 9'(rand_bits(9)), 3'd7});
         end else if (rand_bits(2) == 16'd0) begin
            emit(enc_i(ADDI, rd, rs, 6'(rand_bits(6))));
         end else begin
            emit(enc_r(funct_e'(f), rd, rs, 3'(rand_bits(3))));
         end
         last_rd = rd;
      end
      emit(enc_i(HALT, 3'd0, 3'd0, 6'd0));
      for (k = 0; k < 4; k++) begin
         emit(enc_i(ADDI, 3'(k), 3'(k), 6'd5));
      end
   endtask

   task automatic gen_mem(int pairs);
      logic [2:0] src;
      logic [2:0] dst;
      logic [5:0] off;
      logic [5:0] loff;
      int         k;
      clear_image();
      // r7 = 62, data area above the program
      emit(enc_i(ADDI, 3'd7, 3'd7, 6'd31));
      emit(enc_i(ADDI, 3'd7, 3'd7, 6'd31));
      for (k = 0; k < 7; k++) begin
         emit(enc_i(ADDI, 3'(k), 3'(k), 6'(rand_bits(6))));
      end
      for (k = 0; k < pairs; k++) begin
         src  = pick_reg();
         dst  = pick_reg();
         off  = 6'(rand_bits(4));
         loff = (rand_bits(1) != 16'd0) ? off : 6'(rand_bits(4));
         emit(enc_i(SW, src, 3'd7, off));
         emit(enc_i(LW, dst, 3'd7, loff));
         emit(enc_r(ADD, pick_reg(), dst, src));
      end
      emit(enc_i(HALT, 3'd0, 3'd0, 6'd0));
   endtask

   // Countdown in r1, accumulator in r3, r5 and r6 must stay zero
   task automatic gen_loop();
      clear_image();
      emit(enc_i(ADDI, 3'd1, 3'd1, 6'(rand_bits(3) + 16'd3)));
      emit(enc_i(ADDI, 3'd2, 3'd2, 6'(rand_bits(4) + 16'd1)));
      emit(enc_r(ADD, 3'd3, 3'd3, 3'd2));
      emit(enc_i(ADDI, 3'd2, 3'd2, 6'd1));
      emit(enc_i(ADDI, 3'd1, 3'd1, 6'h3f));
      emit(enc_i(BNEZ, 3'd0, 3'd1, 6'h3c));
      emit(enc_i(ADDI, 3'd4, 3'd4, 6'd1));
      emit(enc_i(BNEZ, 3'd0, 3'd2, 6'd2));
      emit(enc_i(ADDI, 3'd5, 3'd5, 6'd3));
      emit(enc_i(ADDI, 3'd6, 3'd6, 6'd3));
      emit(enc_i(HALT, 3'd0, 3'd0, 6'd0));
      emit(enc_i(ADDI, 3'd5, 3'd5, 6'd9));
      emit(enc_i(ADDI, 3'd6, 3'd6, 6'd9));
   endtask

   // Instruction-set model of the image; ill flags an executed illegal word
   function automatic logic [7:0][15:0] iss_run(output logic ill);
      logic [15:0]            m [MEM_WORDS];
      logic [7:0][15:0]       r;
      instr_u                 w;
      logic [15:0]            imm;
      logic [15:0]            a;
      logic [15:0]            b;
      logic [15:0]            ea;
      logic [`CPU_MEM_AW-1:0] pc;
      logic [`CPU_MEM_AW-1:0] next_pc;
      logic                   done;
      int                     k;
      r    = '0;
      ill  = 1'b0;
      done = 1'b0;
      pc   = `CPU_MEM_AW'(`CPU_RESET_PC);
      for (k = 0; k < MEM_WORDS; k++) begin
         m[k] = image[k];
      end
      for (k = 0; k < 4000 && !done; k++) begin
         w       = m[pc];
         imm     = {{10{w.i.imm[5]}}, w.i.imm};
         a       = r[w.r.rs];
         b       = r[w.r.rt];
         ea      = a + imm;
         next_pc = pc + 1'b1;
         case (w.r.opcode)
            RTYPE: begin
               case (w.r.funct)
                  ADD:     r[w.r.rd] = a + b;
                  SUB:     r[w.r.rd] = a - b;
                  AND:     r[w.r.rd] = a & b;
                  OR:      r[w.r.rd] = a | b;
                  XOR:     r[w.r.rd] = a ^ b;
                  SLT:     r[w.r.rd] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                  default: ill = 1'b1;
               endcase
            end
            ADDI:    r[w.r.rd] = ea;
            LW:      r[w.r.rd] = m[ea[`CPU_MEM_AW-1:0]];
            SW:      m[ea[`CPU_MEM_AW-1:0]] = r[w.r.rd];
            BNEZ: begin
               if (a != 16'd0) begin
                  next_pc = next_pc + imm[`CPU_MEM_AW-1:0];
               end
            end
            HALT:    done = 1'b1;
            default: ill = 1'b1;
         endcase
         pc = next_pc;
      end
      return r;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      rst_n   <= 1'b0;
      run     <= 1'b0;
      load_we <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic load_image();
      int k;
      for (k = 0; k < MEM_WORDS; k++) begin
         @(posedge clk);
         load_we   <= 1'b1;
         load_addr <= `CPU_MEM_AW'(k);
         load_data <= image[k];
      end
      @(posedge clk);
      load_we <= 1'b0;
   endtask

   task automatic run_program();
      int n;
      apply_reset();
      load_image();
      @(posedge clk);
      run <= 1'b1;
      for (n = 0; n < 5000 && halted !== 1'b1; n++) begin
         @(negedge clk);
      end
      if (halted !== 1'b1) begin
         $display("Timeout: halted did not rise in test %s", test_name);
         stop_failed();
      end
      // Let the last writeback settle
      repeat (2) @(posedge clk);
      exp_regs = iss_run(exp_err);
      cmp_done = 1'b0;
      -> cmp_ev;
      for (n = 0; n < 100 && !cmp_done; n++) begin
         @(negedge clk);
      end
      if (!cmp_done) begin
         $display("Timeout: register comparison did not finish in test %s", test_name);
         stop_failed();
      end
   endtask

   // Reads every register through the debug port and compares with the ISS
   initial begin
      int k;
      forever begin
         @(cmp_ev);
         for (k = 0; k < 8; k++) begin
            @(posedge clk);
            dbg_addr <= 3'(k);
            @(negedge clk);
            dut_regs[k] = dbg_data;
            check($sformatf("%s r%0d", test_name, k), exp_regs[k], dbg_data);
         end
         check({test_name, " err"}, 16'(exp_err), 16'(err));
         cmp_done = 1'b1;
      end
   end

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      run       = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      dbg_addr  = '0;
      cmp_done  = 1'b0;

      test_name = "alu_random";
      gen_alu(40, 1'b0);
      run_program();

      test_name = "load_store";
      gen_mem(12);
      run_program();

      test_name = "bnez_loop";
      gen_loop();
      run_program();
      check("bnez_loop counter", 16'd0, dut_regs[1]);
      check("bnez_loop r5 after shadow and halt", 16'd0, dut_regs[5]);
      check("bnez_loop r6 after shadow and halt", 16'd0, dut_regs[6]);

      test_name = "illegal_opcode";
      gen_alu(24, 1'b1);
      run_program();
      check("illegal_opcode err", 16'd1, 16'(err));

      // New image after reset replaces the previous program
      test_name = "reload";
      gen_alu(30, 1'b0);
      run_program();

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== tests/cpu_props.sv ====
// Concurrent checks on memory arbitration and status outputs, bound into every cpu_core
`timescale 1ns/1ps

module cpu_props (
   input logic clk,
   input logic rst_n,
   input logic data_req,
   input logic data_gnt,
   input logic halted,
   input logic err
);

   // Loader is idle while the core runs, so a data access is never refused
   data_granted: assert property (@(posedge clk) disable iff (!rst_n)
      data_req |-> data_gnt)
      else $error("Data request refused by the arbiter");

   halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      halted |=> halted)
      else $error("halted fell without a reset");

   reset_status: assert property (@(posedge clk)
      $rose(rst_n) |-> !err && !halted)
      else $error("err or halted high after reset");

endmodule

bind cpu_core cpu_props i_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .data_req  (data_req),
   .data_gnt  (data_gnt),
   .halted    (halted),
   .err       (err)
);

// ==== src/cpu_core.sv ====
// Top level of the five-stage core tying the stages to the shared memory, load port and debug port
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic                   load_we,
   input  logic [`CPU_MEM_AW-1:0] load_addr,
   input  logic [15:0]            load_data,
   input  logic [2:0]             dbg_addr,
   output logic [15:0]            dbg_data,
   output logic                   halted,
   output logic                   err
);
   import cpu_pkg::*;

   // Hazard and redirect
   logic                   stall;
   logic                   flush;
   logic [`CPU_MEM_AW-1:0] redirect_pc;
   logic                   halt_seen;
   logic                   ex_is_load;
   logic [2:0]             ex_rd;

   // Shared memory ports
   logic                   fetch_req;
   logic                   fetch_gnt;
   logic [`CPU_MEM_AW-1:0] fetch_addr;
   logic                   data_req;
   logic                   data_gnt;
   logic [`CPU_MEM_AW-1:0] data_addr;
   logic                   data_we;
   logic [15:0]            data_wdata;
   logic [15:0]            rdata;

   // Pipeline registers
   instr_u                 if_instr;
   logic [`CPU_MEM_AW-1:0] if_pc;
   logic                   if_valid;
   instr_u                 id_instr;
   logic [`CPU_MEM_AW-1:0] id_pc;
   logic                   id_valid;
   logic [15:0]            id_rs_val;
   logic [15:0]            id_rt_val;
   instr_u                 xm_instr;
   logic                   xm_valid;
   logic [15:0]            xm_result;
   logic [15:0]            xm_store_data;

   // Writeback to the register file and oldest forwarding source
   logic                   wb_we;
   logic [2:0]             wb_reg;
   logic [15:0]            wb_data;

   fetch_stage   i_fetch   (.*);
   decode_stage  i_decode  (.*);
   execute_stage i_execute (.*);
   memory_stage  i_memory  (.*);
   shared_memory i_mem     (.*);

endmodule

// ==== src/shared_memory.sv ====
// Single-port code and data memory behind a fixed-priority arbiter for loader, data and fetch
`timescale 1ns/1ps
`include "cpu_params.svh"

module shared_memory (
   input  logic                   clk,
   input  logic                   load_we,
   input  logic [`CPU_MEM_AW-1:0] load_addr,
   input  logic [15:0]            load_data,
   input  logic                   data_req,
   input  logic [`CPU_MEM_AW-1:0] data_addr,
   input  logic                   data_we,
   input  logic [15:0]            data_wdata,
   input  logic                   fetch_req,
   input  logic [`CPU_MEM_AW-1:0] fetch_addr,
   output logic                   data_gnt,
   output logic                   fetch_gnt,
   output logic [15:0]            rdata
);
   logic [15:0]            mem [2**`CPU_MEM_AW];
   logic [`CPU_MEM_AW-1:0] addr;
   logic                   we;
   logic [15:0]            wdata;

   // Loader always wins and needs no grant
   assign data_gnt  = data_req && !load_we;
   assign fetch_gnt = fetch_req && !load_we && !data_req;

   assign addr  = load_we ? load_addr : (data_req ? data_addr : fetch_addr);
   assign we    = load_we || (data_gnt && data_we);
   assign wdata = load_we ? load_data : data_wdata;

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

// ==== src/memory_stage.sv ====
// Memory stage issuing lw and sw accesses and producing the writeback register and value
`timescale 1ns/1ps
`include "cpu_params.svh"

module memory_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cpu_pkg::instr_u        xm_instr,
   input  logic                   xm_valid,
   input  logic [15:0]            xm_result,
   input  logic [15:0]            xm_store_data,
   input  logic                   data_gnt,
   input  logic [15:0]            rdata,
   output logic                   data_req,
   output logic [`CPU_MEM_AW-1:0] data_addr,
   output logic                   data_we,
   output logic [15:0]            data_wdata,
   output logic                   wb_we,
   output logic [2:0]             wb_reg,
   output logic [15:0]            wb_data,
   output logic                   halted
);
   import cpu_pkg::*;

   opcode_e         xm_op;
   cpu_pkg::instr_u mw_instr;
   logic            mw_valid;
   logic [15:0]     mw_result;

   assign xm_op      = xm_instr.r.opcode;
   assign data_req   = xm_valid && (xm_op == LW || xm_op == SW);
   assign data_addr  = xm_result[`CPU_MEM_AW-1:0];
   assign data_we    = data_req && xm_op == SW;
   assign data_wdata = xm_store_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mw_valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         // Drop an access the arbiter refused
         mw_valid <= xm_valid && (data_gnt || !data_req);
         if (xm_valid && xm_op == HALT) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      mw_instr  <= xm_instr;
      mw_result <= xm_result;
   end

   assign wb_we   = mw_valid && writes_reg(mw_instr.r.opcode);
   assign wb_reg  = mw_instr.r.rd;
   // Load word shows up on rdata one cycle after its request
   assign wb_data = (mw_instr.r.opcode == LW) ? rdata : mw_result;

endmodule

// ==== src/execute_stage.sv ====
// Execute stage with operand forwarding, ALU, bnez resolution, halt detection and execute/memory register
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cpu_pkg::instr_u        id_instr,
   input  logic [`CPU_MEM_AW-1:0] id_pc,
   input  logic                   id_valid,
   input  logic [15:0]            id_rs_val,
   input  logic [15:0]            id_rt_val,
   input  logic                   wb_we,
   input  logic [2:0]             wb_reg,
   input  logic [15:0]            wb_data,
   output logic                   flush,
   output logic [`CPU_MEM_AW-1:0] redirect_pc,
   output logic                   halt_seen,
   output logic                   ex_is_load,
   output logic [2:0]             ex_rd,
   output cpu_pkg::instr_u        xm_instr,
   output logic                   xm_valid,
   output logic [15:0]            xm_result,
   output logic [15:0]            xm_store_data
);
   import cpu_pkg::*;

   opcode_e     op;
   logic [2:0]  src_a;
   logic [2:0]  src_b;
   logic        xm_fwd_ok;
   logic [15:0] op_a;
   logic [15:0] op_b;
   logic [15:0] imm_ext;
   logic [15:0] alu_out;
   logic [15:0] target;
   logic        taken;
   logic        is_halt;

   assign op      = id_instr.r.opcode;
   assign src_a   = id_instr.r.rs;
   assign src_b   = (op == SW) ? id_instr.r.rd : id_instr.r.rt;
   assign imm_ext = {{10{id_instr.i.imm[5]}}, id_instr.i.imm};

   // Memory-stage register holds ALU results only; a load there is covered by the stall
   assign xm_fwd_ok = xm_valid && writes_reg(xm_instr.r.opcode) && xm_instr.r.opcode != LW;

   // Youngest result first
   assign op_a = (xm_fwd_ok && xm_instr.r.rd == src_a) ? xm_result :
                 (wb_we && wb_reg == src_a)            ? wb_data   : id_rs_val;
   assign op_b = (xm_fwd_ok && xm_instr.r.rd == src_b) ? xm_result :
                 (wb_we && wb_reg == src_b)            ? wb_data   : id_rt_val;

   always_comb begin
      // Effective address for addi, lw and sw
      alu_out = op_a + imm_ext;
      if (op == RTYPE) begin
         case (id_instr.r.funct)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            default: alu_out = {15'd0, $signed(op_a) < $signed(op_b)};
         endcase
      end
   end

   assign taken       = id_valid && op == BNEZ && op_a != 16'd0;
   assign is_halt     = id_valid && op == HALT;
   assign target      = 16'(id_pc) + 16'd1 + imm_ext;
   assign redirect_pc = target[`CPU_MEM_AW-1:0];
   assign flush       = taken || is_halt;
   assign ex_is_load  = id_valid && op == LW;
   assign ex_rd       = id_instr.r.rd;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         xm_valid  <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         xm_valid <= id_valid;
         if (is_halt) begin
            halt_seen <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      xm_instr      <= id_instr;
      xm_result     <= alu_out;
      xm_store_data <= op_b;
   end

endmodule

// ==== src/decode_stage.sv ====
// Decode stage with the register file, load-use stall, illegal opcode check and decode/execute register
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cpu_pkg::instr_u        if_instr,
   input  logic [`CPU_MEM_AW-1:0] if_pc,
   input  logic                   if_valid,
   input  logic                   flush,
   input  logic                   wb_we,
   input  logic [2:0]             wb_reg,
   input  logic [15:0]            wb_data,
   input  logic                   ex_is_load,
   input  logic [2:0]             ex_rd,
   input  logic [2:0]             dbg_addr,
   output logic                   stall,
   output logic                   err,
   output cpu_pkg::instr_u        id_instr,
   output logic [`CPU_MEM_AW-1:0] id_pc,
   output logic                   id_valid,
   output logic [15:0]            id_rs_val,
   output logic [15:0]            id_rt_val,
   output logic [15:0]            dbg_data
);
   import cpu_pkg::*;

   logic [15:0] regs [8];
   opcode_e     op;
   logic [2:0]  src_a;
   logic [2:0]  src_b;
   logic        uses_a;
   logic        uses_b;
   logic        legal;
   logic [15:0] rs_val;
   logic [15:0] rt_val;

   assign op     = if_instr.r.opcode;
   assign src_a  = if_instr.r.rs;
   // Store data comes from the register in the rd field
   assign src_b  = (op == SW) ? if_instr.r.rd : if_instr.r.rt;
   assign uses_a = op inside {RTYPE, ADDI, LW, SW, BNEZ};
   assign uses_b = op inside {RTYPE, SW};
   assign legal  = (op == RTYPE) ? (if_instr.r.funct inside {ADD, SUB, AND, OR, XOR, SLT})
                                 : (op inside {ADDI, LW, SW, BNEZ, HALT});

   // Load result is not ready until writeback
   assign stall = if_valid && legal && ex_is_load &&
                  ((uses_a && ex_rd == src_a) || (uses_b && ex_rd == src_b));

   // Same-cycle writeback bypasses the array
   assign rs_val   = (wb_we && wb_reg == src_a) ? wb_data : regs[src_a];
   assign rt_val   = (wb_we && wb_reg == src_b) ? wb_data : regs[src_b];
   assign dbg_data = regs[dbg_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we) begin
         regs[wb_reg] <= wb_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_valid <= 1'b0;
         err      <= 1'b0;
      end else begin
         id_valid <= if_valid && legal && !stall && !flush;
         // Illegal word goes on as a bubble
         if (if_valid && !legal && !flush) begin
            err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      id_instr  <= if_instr;
      id_pc     <= if_pc;
      id_rs_val <= rs_val;
      id_rt_val <= rt_val;
   end

endmodule

// ==== src/fetch_stage.sv ====
// Fetch stage holding the PC, issuing reads to the shared memory and feeding the decode register
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic                   stall,
   input  logic                   flush,
   input  logic [`CPU_MEM_AW-1:0] redirect_pc,
   input  logic                   halt_seen,
   input  logic                   fetch_gnt,
   input  logic [15:0]            rdata,
   output logic                   fetch_req,
   output logic [`CPU_MEM_AW-1:0] fetch_addr,
   output cpu_pkg::instr_u        if_instr,
   output logic [`CPU_MEM_AW-1:0] if_pc,
   output logic                   if_valid
);
   logic [`CPU_MEM_AW-1:0] pc;
   logic                   pending;
   logic [`CPU_MEM_AW-1:0] pending_pc;

   assign fetch_req  = run && !stall && !flush && !halt_seen;
   assign fetch_addr = pc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= `CPU_MEM_AW'(`CPU_RESET_PC);
         pending  <= 1'b0;
         if_valid <= 1'b0;
      end else if (!run) begin
         pc       <= `CPU_MEM_AW'(`CPU_RESET_PC);
         pending  <= 1'b0;
         if_valid <= 1'b0;
      end else if (flush) begin
         pc       <= redirect_pc;
         pending  <= 1'b0;
         if_valid <= 1'b0;
      end else if (stall) begin
         // Decode is full so the word in flight is dropped and read again
         if (pending) begin
            pc <= pending_pc;
         end
         pending <= 1'b0;
      end else begin
         if (fetch_gnt) begin
            pc <= pc + 1'b1;
         end
         pending  <= fetch_gnt;
         if_valid <= pending;
      end
   end

   // Word returns one cycle after the grant
   always_ff @(posedge clk) begin
      if (fetch_gnt) begin
         pending_pc <= pc;
      end
      if (pending && !stall) begin
         if_instr <= rdata;
         if_pc    <= pending_pc;
      end
   end

endmodule

// ==== src/cpu_pkg.sv ====
// Opcode, ALU function and instruction format types of the 16-bit core, imported by the stages
package cpu_pkg;

   // Major opcode in bits 15:12; all other codes are illegal
   typedef enum logic [3:0] {
      RTYPE = 4'h0,
      ADDI  = 4'h1,
      LW    = 4'h2,
      SW    = 4'h3,
      BNEZ  = 4'h4,
      HALT  = 4'hf
   } opcode_e;

   // ALU function of an RTYPE instruction; codes 6 and 7 are illegal
   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      SLT = 3'd5
   } funct_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      funct_e     funct;
   } rtype_t;

   typedef struct packed {
      opcode_e           opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } itype_t;

   // One instruction word read as either format
   typedef union packed {
      rtype_t r;
      itype_t i;
   } instr_u;

   // Instructions that write rd at writeback
   function automatic logic writes_reg(opcode_e op);
      return op == RTYPE || op == ADDI || op == LW;
   endfunction

endpackage

// ==== src/cpu_params.svh ====
// Memory geometry and reset PC for the core and its testbench, pulled in with `include
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word address width of the shared memory (2**AW words of 16 bits)
`define CPU_MEM_AW 8

// Address of the first instruction after reset and while run is low
`define CPU_RESET_PC 0

`endif
